/* include/tag_rx_defines.svh */
`ifndef TAG_RX_DEFINES_SVH
`define TAG_RX_DEFINES_SVH

// ********************************************************************
// datapath widths.
`define TAG_DATA_W     16
`define TAG_PHASE_W    24
`define TAG_NSYMB_W    16
`define TAG_SCALE_W    16
`define TAG_SYNC_BITS  4
`define TAG_CFG_W      32

// table index bits, two of them select the quadrant.
`define TAG_LUT_BITS   7
`define TAG_QTR_BITS   (`TAG_LUT_BITS - 2)

// mixer output width and the fraction bits dropped after each product.
`define TAG_MIX_W      (2 * `TAG_DATA_W + 1)
`define TAG_MIX_FRAC   15
`define TAG_SCALE_FRAC 12

// ********************************************************************
// configuration after reset.
`define TAG_RST_START_INC 24'h020000
`define TAG_RST_DPH_INC   24'h004000
`define TAG_RST_NSIG      24'd64
`define TAG_RST_NSYMB     16'd8
`define TAG_RST_SCALE     16'h1000

`endif

/* verilog/tag_rx_pkg.sv */
`default_nettype none

`include "tag_rx_defines.svh"

package tag_rx_pkg;

  typedef logic signed [`TAG_DATA_W-1:0] sample_t;
  typedef logic [`TAG_PHASE_W-1:0] phase_t;

  // addresses 0 to 2 carry a phase-sized value in the low bits.
  typedef struct packed {
    logic [`TAG_CFG_W-`TAG_PHASE_W-1:0] pad;
    phase_t                             value;
  } cfg_phase_t;

  // address 3 carries the frame length and the output scale together.
  typedef struct packed {
    logic [`TAG_NSYMB_W-1:0] nsymb;
    logic [`TAG_SCALE_W-1:0] scale;
  } cfg_count_t;

  typedef union packed {
    cfg_phase_t ph;
    cfg_count_t cnt;
  } cfg_word_u;

endpackage

`default_nettype wire

/* verilog/chirp_cfg_if.sv */
`default_nettype none

`include "tag_rx_defines.svh"

interface chirp_cfg_if;
  import tag_rx_pkg::*;

  phase_t                  start_inc;
  phase_t                  dph_inc;
  phase_t                  nsig;
  logic [`TAG_NSYMB_W-1:0] nsymb;

  modport regs (output start_inc, dph_inc, nsig, nsymb);
  modport gen  (input start_inc, dph_inc, nsig, nsymb);

endinterface

`default_nettype wire

/* verilog/chirp_cfg_regs.sv */
`default_nettype none

`include "tag_rx_defines.svh"

module chirp_cfg_regs (
  input  wire                      clk,
  input  wire                      i_rst_n,
  input  wire                      i_cfg_we,
  input  wire [1:0]                i_cfg_addr,
  input  tag_rx_pkg::cfg_word_u    i_cfg_wdata,
  chirp_cfg_if.regs                cfg,
  output logic [`TAG_SCALE_W-1:0]  o_scale
);
  import tag_rx_pkg::*;

  phase_t                  start_inc_q;
  phase_t                  dph_inc_q;
  phase_t                  nsig_q;
  logic [`TAG_NSYMB_W-1:0] nsymb_q;
  logic [`TAG_SCALE_W-1:0] scale_q;

  // the address picks which view of the word is meaningful.
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      start_inc_q <= `TAG_RST_START_INC;
      dph_inc_q   <= `TAG_RST_DPH_INC;
      nsig_q      <= `TAG_RST_NSIG;
      nsymb_q     <= `TAG_RST_NSYMB;
      scale_q     <= `TAG_RST_SCALE;
    end else if (i_cfg_we) begin
      case (i_cfg_addr)
        2'd0: start_inc_q <= i_cfg_wdata.ph.value;
        2'd1: dph_inc_q   <= i_cfg_wdata.ph.value;
        2'd2: nsig_q      <= i_cfg_wdata.ph.value;
        default: begin
          nsymb_q <= i_cfg_wdata.cnt.nsymb;
          scale_q <= i_cfg_wdata.cnt.scale;
        end
      endcase
    end
  end

  assign cfg.start_inc = start_inc_q;
  assign cfg.dph_inc   = dph_inc_q;
  assign cfg.nsig      = nsig_q;
  assign cfg.nsymb     = nsymb_q;
  assign o_scale       = scale_q;

endmodule

`default_nettype wire

/* verilog/chirp_phase_gen.sv */
`default_nettype none

`include "tag_rx_defines.svh"

module chirp_phase_gen (
  input  wire                 clk,
  input  wire                 i_rst_n,
  input  wire                 i_srst,
  input  wire                 i_step,
  chirp_cfg_if.gen            cfg,
  output tag_rx_pkg::phase_t  o_phase,
  output logic                o_sync_ready
);
  import tag_rx_pkg::*;

  phase_t                    phase_q;
  phase_t                    inc_q;
  phase_t                    dph_q;
  phase_t                    nsig_q;
  logic [`TAG_NSYMB_W-1:0]   nsymb_q;
  phase_t                    sig_cnt;
  logic [`TAG_NSYMB_W-1:0]   symb_cnt;
  logic [`TAG_SYNC_BITS-1:0] frame_cnt;
  logic                      primed;

  // counters start at their limits so the first sample opens a frame.
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      phase_q   <= '0;
      inc_q     <= `TAG_RST_START_INC;
      dph_q     <= `TAG_RST_DPH_INC;
      nsig_q    <= `TAG_RST_NSIG;
      nsymb_q   <= `TAG_RST_NSYMB;
      sig_cnt   <= `TAG_RST_NSIG;
      symb_cnt  <= `TAG_RST_NSYMB;
      frame_cnt <= '0;
      primed    <= 1'b0;
    end else if (i_srst) begin
      phase_q   <= '0;
      inc_q     <= cfg.start_inc;
      dph_q     <= cfg.dph_inc;
      nsig_q    <= cfg.nsig;
      nsymb_q   <= cfg.nsymb;
      sig_cnt   <= cfg.nsig;
      symb_cnt  <= cfg.nsymb;
      frame_cnt <= '0;
      primed    <= 1'b0;
    end else if (i_step) begin
      if (sig_cnt == nsig_q) begin
        sig_cnt <= phase_t'(1);
        phase_q <= '0;
        if (symb_cnt == nsymb_q) begin
          // frame boundary, new settings take effect here.
          symb_cnt <= `TAG_NSYMB_W'(1);
          inc_q    <= cfg.start_inc;
          dph_q    <= cfg.dph_inc;
          nsig_q   <= cfg.nsig;
          nsymb_q  <= cfg.nsymb;
          primed   <= 1'b1;
          if (primed && !o_sync_ready)
            frame_cnt <= frame_cnt + 1'b1;
        end else begin
          symb_cnt <= symb_cnt + 1'b1;
          inc_q    <= inc_q + dph_q;
        end
      end else begin
        phase_q <= phase_q + inc_q;
        sig_cnt <= sig_cnt + 1'b1;
      end
    end
  end

  assign o_phase      = phase_q;
  assign o_sync_ready = &frame_cnt;

endmodule

`default_nettype wire

/* verilog/dechirp_mixer.sv */
`default_nettype none

`include "tag_rx_defines.svh"

module dechirp_mixer (
  input  wire                              clk,
  input  wire                              i_rst_n,
  input  wire                              i_adv,
  input  wire                              i_valid,
  input  tag_rx_pkg::sample_t              i_i,
  input  tag_rx_pkg::sample_t              i_q,
  input  tag_rx_pkg::phase_t               i_phase,
  output logic                             o_valid,
  output logic signed [`TAG_MIX_W-1:0]     o_i,
  output logic signed [`TAG_MIX_W-1:0]     o_q
);
  import tag_rx_pkg::*;

  // first quadrant of the sine, Q1.15.
  sample_t sin_rom [0:(1 << `TAG_QTR_BITS)-1];

  initial begin
    $readmemh("sin_table.hex", sin_rom);
  end

  // the full turn is folded onto the quarter table by mirroring and negation.
  function automatic sample_t lut_sin(input logic [`TAG_LUT_BITS-1:0] idx);
    logic [`TAG_QTR_BITS-1:0] off;
    logic [`TAG_QTR_BITS-1:0] mirror;
    sample_t                  mag;
    off    = idx[`TAG_QTR_BITS-1:0];
    mirror = '0 - off;
    if (idx[`TAG_LUT_BITS-2]) begin
      if (off == '0)
        mag = {1'b0, {(`TAG_DATA_W-1){1'b1}}};
      else
        mag = sin_rom[mirror];
    end else begin
      mag = sin_rom[off];
    end
    lut_sin = idx[`TAG_LUT_BITS-1] ? -mag : mag;
  endfunction

  logic [`TAG_LUT_BITS-1:0] sin_idx;
  logic [`TAG_LUT_BITS-1:0] cos_idx;

  // cosine is a quarter turn ahead of the sine.
  assign sin_idx = i_phase[`TAG_PHASE_W-1 -: `TAG_LUT_BITS];
  assign cos_idx = {sin_idx[`TAG_LUT_BITS-1 -: 2] + 2'b01, sin_idx[`TAG_QTR_BITS-1:0]};

  logic    s1_valid;
  sample_t s1_i;
  sample_t s1_q;
  sample_t s1_sin;
  sample_t s1_cos;

  logic signed [`TAG_MIX_W-1:0] prod_ic;
  logic signed [`TAG_MIX_W-1:0] prod_qs;
  logic signed [`TAG_MIX_W-1:0] prod_qc;
  logic signed [`TAG_MIX_W-1:0] prod_is;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s1_valid <= 1'b0;
      o_valid  <= 1'b0;
    end else if (i_adv) begin
      s1_valid <= i_valid;
      o_valid  <= s1_valid;
    end
  end

  // ********************************************************************
  // table lookup, then multiply by the conjugate phasor.
  always_ff @(posedge clk) begin
    if (i_adv) begin
      s1_i   <= i_i;
      s1_q   <= i_q;
      s1_sin <= lut_sin(sin_idx);
      s1_cos <= lut_sin(cos_idx);
    end
  end

  assign prod_ic = s1_i * s1_cos;
  assign prod_qs = s1_q * s1_sin;
  assign prod_qc = s1_q * s1_cos;
  assign prod_is = s1_i * s1_sin;

  always_ff @(posedge clk) begin
    if (i_adv) begin
      o_i <= prod_ic + prod_qs;
      o_q <= prod_qc - prod_is;
    end
  end

endmodule

`default_nettype wire

/* verilog/scale_round_clip.sv */
`default_nettype none

`include "tag_rx_defines.svh"

module scale_round_clip (
  input  wire                           clk,
  input  wire                           i_rst_n,
  input  wire                           i_adv,
  input  wire                           i_valid,
  input  wire signed [`TAG_MIX_W-1:0]   i_i,
  input  wire signed [`TAG_MIX_W-1:0]   i_q,
  input  wire [`TAG_SCALE_W-1:0]        i_scale,
  output logic                          o_valid,
  output tag_rx_pkg::sample_t           o_i,
  output tag_rx_pkg::sample_t           o_q
);
  import tag_rx_pkg::*;

  localparam int XS_W = `TAG_MIX_W - `TAG_MIX_FRAC + 1;
  localparam int PR_W = XS_W + `TAG_SCALE_W + 1;
  localparam int PS_W = PR_W - `TAG_SCALE_FRAC;

  // both roundings are half up, the add comes before an arithmetic shift.
  function automatic sample_t rsc(input logic signed [`TAG_MIX_W-1:0] x,
                                  input logic [`TAG_SCALE_W-1:0] s);
    logic signed [`TAG_MIX_W:0] xr;
    logic signed [XS_W-1:0]     xs;
    logic signed [PR_W-1:0]     pr;
    logic signed [PS_W-1:0]     ps;
    xr = x + (1 << (`TAG_MIX_FRAC - 1));
    xs = xr[`TAG_MIX_W:`TAG_MIX_FRAC];
    pr = xs * $signed({1'b0, s});
    pr = pr + (1 << (`TAG_SCALE_FRAC - 1));
    ps = pr[PR_W-1:`TAG_SCALE_FRAC];
    // saturate when the dropped top bits are not all copies of the sign.
    if (ps[PS_W-1:`TAG_DATA_W-1] == {(PS_W-`TAG_DATA_W+1){ps[PS_W-1]}})
      rsc = ps[`TAG_DATA_W-1:0];
    else
      rsc = {ps[PS_W-1], {(`TAG_DATA_W-1){~ps[PS_W-1]}}};
  endfunction

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n)
      o_valid <= 1'b0;
    else if (i_adv)
      o_valid <= i_valid;
  end

  always_ff @(posedge clk) begin
    if (i_adv) begin
      o_i <= rsc(i_i, i_scale);
      o_q <= rsc(i_q, i_scale);
    end
  end

endmodule

`default_nettype wire

/* verilog/tag_rx.sv */
`default_nettype none

`include "tag_rx_defines.svh"

module tag_rx (
  input  wire                     clk,
  input  wire                     i_rst_n,
  input  wire                     i_srst,
  input  wire                     i_cfg_we,
  input  wire [1:0]               i_cfg_addr,
  input  wire [`TAG_CFG_W-1:0]    i_cfg_wdata,
  input  wire                     i_in_valid,
  input  tag_rx_pkg::sample_t     i_in_i,
  input  tag_rx_pkg::sample_t     i_in_q,
  output logic                    o_in_ready,
  input  wire                     i_out_ready,
  output logic                    o_out_valid,
  output tag_rx_pkg::sample_t     o_out_i,
  output tag_rx_pkg::sample_t     o_out_q,
  output logic                    o_sync_ready
);
  import tag_rx_pkg::*;

  chirp_cfg_if cfg_bus ();

  logic [`TAG_SCALE_W-1:0]       scale;
  phase_t                        phase;
  logic                          step;
  logic                          mix_valid;
  logic signed [`TAG_MIX_W-1:0]  mix_i;
  logic signed [`TAG_MIX_W-1:0]  mix_q;

  // ********************************************************************
  // one stall signal moves all three stages together.
  assign o_in_ready = i_out_ready;
  assign step       = i_in_valid & i_out_ready;

  chirp_cfg_regs u_regs (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_cfg_we    (i_cfg_we),
    .i_cfg_addr  (i_cfg_addr),
    .i_cfg_wdata (i_cfg_wdata),
    .cfg         (cfg_bus.regs),
    .o_scale     (scale)
  );

  chirp_phase_gen u_gen (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_srst       (i_srst),
    .i_step       (step),
    .cfg          (cfg_bus.gen),
    .o_phase      (phase),
    .o_sync_ready (o_sync_ready)
  );

  dechirp_mixer u_mix (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_adv   (i_out_ready),
    .i_valid (i_in_valid),
    .i_i     (i_in_i),
    .i_q     (i_in_q),
    .i_phase (phase),
    .o_valid (mix_valid),
    .o_i     (mix_i),
    .o_q     (mix_q)
  );

  scale_round_clip u_scale (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_adv   (i_out_ready),
    .i_valid (mix_valid),
    .i_i     (mix_i),
    .i_q     (mix_q),
    .i_scale (scale),
    .o_valid (o_out_valid),
    .o_i     (o_out_i),
    .o_q     (o_out_q)
  );

endmodule

`default_nettype wire

/* bench/tag_rx_tb.sv */
`default_nettype none

`include "tag_rx_defines.svh"

module tag_rx_tb;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 16;
  localparam int TURN       = 1 << `TAG_LUT_BITS;
  localparam int QTR        = TURN / 4;
  localparam int FRAME_MAX  = (1 << `TAG_SYNC_BITS) - 1;
  localparam int N_BASE     = 200;
  localparam int N_CFG      = 200;
  localparam int CFG_ROUNDS = 3;
  localparam int N_STALL    = 400;
  localparam int N_SAT      = 120;
  localparam int N_SYNC     = 70;
  localparam int N_TOTAL    = N_BASE + CFG_ROUNDS * N_CFG + N_STALL + N_SAT + N_SYNC;
  // stalled samples take several cycles each and the configuration and drain phases add more.
  localparam int WATCHDOG_CYCLES = RST_CYCLES + 8 * N_TOTAL + 500;

  logic                           clk;
  logic                           rst_n;
  logic                           srst;
  logic                           cfg_we;
  logic [1:0]                     cfg_addr;
  logic [`TAG_CFG_W-1:0]          cfg_wdata;
  logic                           in_valid;
  logic signed [`TAG_DATA_W-1:0]  in_i;
  logic signed [`TAG_DATA_W-1:0]  in_q;
  logic                           o_in_ready;
  logic                           out_ready;
  logic                           o_out_valid;
  logic signed [`TAG_DATA_W-1:0]  o_out_i;
  logic signed [`TAG_DATA_W-1:0]  o_out_q;
  logic                           o_sync_ready;

  // reference model state.
  logic signed [`TAG_DATA_W-1:0]  sin_tbl [0:QTR-1];
  logic [2*`TAG_DATA_W-1:0]       expected_q [$];
  logic [`TAG_PHASE_W-1:0]        m_start;
  logic [`TAG_PHASE_W-1:0]        m_dph;
  logic [`TAG_PHASE_W-1:0]        m_nsig;
  logic [`TAG_NSYMB_W-1:0]        m_nsymb;
  logic [`TAG_SCALE_W-1:0]        m_scale;
  logic [`TAG_PHASE_W-1:0]        g_phase;
  logic [`TAG_PHASE_W-1:0]        g_inc;
  logic [`TAG_PHASE_W-1:0]        g_dph;
  logic [`TAG_PHASE_W-1:0]        g_nsig;
  logic [`TAG_NSYMB_W-1:0]        g_nsymb;
  logic [`TAG_PHASE_W-1:0]        g_sig_cnt;
  logic [`TAG_NSYMB_W-1:0]        g_symb_cnt;
  int                             g_frames;
  bit                             g_first_seen;
  int                             sat_count;
  bit                             hold_pending;
  logic signed [`TAG_DATA_W-1:0]  held_i;
  logic signed [`TAG_DATA_W-1:0]  held_q;
  int                             sat_before;

  tag_rx UUT (
    .clk          (clk),
    .i_rst_n      (rst_n),
    .i_srst       (srst),
    .i_cfg_we     (cfg_we),
    .i_cfg_addr   (cfg_addr),
    .i_cfg_wdata  (cfg_wdata),
    .i_in_valid   (in_valid),
    .i_in_i       (in_i),
    .i_in_q       (in_q),
    .o_in_ready   (o_in_ready),
    .i_out_ready  (out_ready),
    .o_out_valid  (o_out_valid),
    .o_out_i      (o_out_i),
    .o_out_q      (o_out_q),
    .o_sync_ready (o_sync_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    $readmemh("sin_table.hex", sin_tbl);
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_with_failure("watchdog expired, the run took far longer than its sample count allows");
  end

  // ********************************************************************
  // reference model of the chirp generator and the output arithmetic.
  function automatic longint table_sine(input int k);
    int     quad;
    int     r;
    longint mag;
    quad = k / QTR;
    r    = k % QTR;
    // the second and fourth quadrants run the table backwards.
    if (quad == 1 || quad == 3)
      mag = (r == 0) ? longint'(32767) : longint'(sin_tbl[QTR - r]);
    else
      mag = sin_tbl[r];
    return (quad >= 2) ? -mag : mag;
  endfunction

  task automatic clip_to_sample(input longint m, output logic signed [`TAG_DATA_W-1:0] y);
    longint a;
    longint p;
    longint b;
    longint scl;
    scl = m_scale;
    a   = (m + 64'sd16384) >>> 15;
    p   = a * scl;
    b   = (p + 64'sd2048) >>> 12;
    if (b > 32767) begin
      y = 16'sh7fff;
    end else if (b < -32768) begin
      y = 16'sh8000;
    end else begin
      y = b[`TAG_DATA_W-1:0];
    end
  endtask

  task automatic model_restart();
    g_phase      = '0;
    g_inc        = m_start;
    g_dph        = m_dph;
    g_nsig       = m_nsig;
    g_nsymb      = m_nsymb;
    g_sig_cnt    = m_nsig;
    g_symb_cnt   = m_nsymb;
    g_frames     = 0;
    g_first_seen = 1'b0;
  endtask

  task automatic model_reset();
    m_start = `TAG_RST_START_INC;
    m_dph   = `TAG_RST_DPH_INC;
    m_nsig  = `TAG_RST_NSIG;
    m_nsymb = `TAG_RST_NSYMB;
    m_scale = `TAG_RST_SCALE;
    model_restart();
  endtask

  task automatic model_write(input logic [1:0] addr, input logic [`TAG_CFG_W-1:0] data);
    case (addr)
      2'd0: m_start = data[`TAG_PHASE_W-1:0];
      2'd1: m_dph   = data[`TAG_PHASE_W-1:0];
      2'd2: m_nsig  = data[`TAG_PHASE_W-1:0];
      default: begin
        m_nsymb = data[`TAG_CFG_W-1 -: `TAG_NSYMB_W];
        m_scale = data[`TAG_SCALE_W-1:0];
      end
    endcase
  endtask

  task automatic model_step(input logic signed [`TAG_DATA_W-1:0] si,
                            input logic signed [`TAG_DATA_W-1:0] sq);
    int                            k;
    longint                        s;
    longint                        c;
    logic signed [`TAG_DATA_W-1:0] yi;
    logic signed [`TAG_DATA_W-1:0] yq;
    k = g_phase[`TAG_PHASE_W-1 -: `TAG_LUT_BITS];
    s = table_sine(k);
    c = table_sine((k + QTR) % TURN);
    clip_to_sample(longint'(si) * c + longint'(sq) * s, yi);
    clip_to_sample(longint'(sq) * c - longint'(si) * s, yq);
    expected_q.push_back({yi, yq});
    if (g_sig_cnt == g_nsig) begin
      g_sig_cnt = 1;
      g_phase   = '0;
      if (g_symb_cnt == g_nsymb) begin
        g_symb_cnt = 1;
        g_inc      = m_start;
        g_dph      = m_dph;
        g_nsig     = m_nsig;
        g_nsymb    = m_nsymb;
        // the rollover that opens the very first frame completes nothing.
        if (g_first_seen && g_frames < FRAME_MAX)
          g_frames++;
        g_first_seen = 1'b1;
      end else begin
        g_symb_cnt = g_symb_cnt + 1'b1;
        g_inc      = g_inc + g_dph;
      end
    end else begin
      g_phase   = g_phase + g_inc;
      g_sig_cnt = g_sig_cnt + 1'b1;
    end
  endtask

  // ********************************************************************
  // the monitor samples at the falling edge halfway between transfers.
  always @(negedge clk) begin
    logic [2*`TAG_DATA_W-1:0] pair;
    if (!rst_n) begin
      model_reset();
      hold_pending = 1'b0;
    end else begin
      assert (o_in_ready === out_ready) else
        stop_with_failure($sformatf("** Error: o_in_ready expected %h got %h",
                                    out_ready, o_in_ready));
      assert (o_sync_ready === (g_frames == FRAME_MAX)) else
        stop_with_failure($sformatf("** Error: o_sync_ready expected %h got %h",
                                    (g_frames == FRAME_MAX), o_sync_ready));
      if (hold_pending) begin
        assert (o_out_valid === 1'b1) else
          stop_with_failure("o_out_valid dropped while the output was stalled");
        assert (o_out_i === held_i) else
          stop_with_failure($sformatf("** Error: o_out_i held %h changed to %h",
                                      held_i, o_out_i));
        assert (o_out_q === held_q) else
          stop_with_failure($sformatf("** Error: o_out_q held %h changed to %h",
                                      held_q, o_out_q));
      end
      if (o_out_valid && out_ready) begin
        assert (expected_q.size() != 0) else
          stop_with_failure("an output transferred while the model expected none");
        pair = expected_q.pop_front();
        assert (o_out_i === pair[2*`TAG_DATA_W-1 -: `TAG_DATA_W]) else
          stop_with_failure($sformatf("** Error: o_out_i expected %h got %h",
                                      pair[2*`TAG_DATA_W-1 -: `TAG_DATA_W], o_out_i));
        assert (o_out_q === pair[`TAG_DATA_W-1:0]) else
          stop_with_failure($sformatf("** Error: o_out_q expected %h got %h",
                                      pair[`TAG_DATA_W-1:0], o_out_q));
        // outputs at either rail show that the scaler clipped.
        if (o_out_i == 16'sh7fff || o_out_i == 16'sh8000 ||
            o_out_q == 16'sh7fff || o_out_q == 16'sh8000)
          sat_count++;
      end
      hold_pending = o_out_valid && !out_ready;
      held_i       = o_out_i;
      held_q       = o_out_q;
      if (srst)
        model_restart();
      else if (in_valid && out_ready)
        model_step(in_i, in_q);
      if (cfg_we)
        model_write(cfg_addr, cfg_wdata);
    end
  end

  // ********************************************************************
  // stimulus.
  task automatic write_cfg(input logic [1:0] addr, input logic [`TAG_CFG_W-1:0] data);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_we    <= 1'b0;
  endtask

  task automatic pulse_srst();
    @(posedge clk);
    srst <= 1'b1;
    @(posedge clk);
    srst <= 1'b0;
  endtask

  task automatic random_config();
    write_cfg(2'd0, {8'($urandom), 24'($urandom)});
    write_cfg(2'd1, {8'($urandom), 24'($urandom_range(24'h00ffff, 0))});
    write_cfg(2'd2, {8'($urandom), 24'($urandom_range(24, 1))});
    write_cfg(2'd3, {16'($urandom_range(6, 1)), 16'($urandom_range(16'h3000, 16'h0400))});
  endtask

  task automatic send_samples(input int n, input int valid_pct, input int ready_pct,
                              input bit full_scale);
    int sent;
    sent = 0;
    while (sent < n) begin
      @(posedge clk);
      if (in_valid && out_ready)
        sent++;
      out_ready <= ($urandom_range(99, 0) < ready_pct);
      if (sent < n) begin
        in_valid <= ($urandom_range(99, 0) < valid_pct);
        if (full_scale) begin
          in_i <= $urandom_range(1, 0) ? 16'sh7fff : 16'sh8000;
          in_q <= $urandom_range(1, 0) ? 16'sh7fff : 16'sh8000;
        end else begin
          in_i <= 16'($urandom);
          in_q <= 16'($urandom);
        end
      end else begin
        in_valid <= 1'b0;
      end
    end
  endtask

  task automatic drain_pipeline();
    @(posedge clk);
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    while (expected_q.size() != 0)
      @(posedge clk);
    @(posedge clk);
  endtask

  initial begin
    void'($urandom(32'h96e1_ab46));
    rst_n     <= 1'b0;
    srst      <= 1'b0;
    cfg_we    <= 1'b0;
    cfg_addr  <= '0;
    cfg_wdata <= '0;
    in_valid  <= 1'b0;
    in_i      <= '0;
    in_q      <= '0;
    out_ready <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!o_out_valid && !o_sync_ready) else
      stop_with_failure("o_out_valid or o_sync_ready was high right after reset");

    // default configuration.
    send_samples(N_BASE, 80, 100, 1'b0);
    drain_pipeline();

    // random settings on every address and a restart after each set.
    repeat (CFG_ROUNDS) begin
      random_config();
      pulse_srst();
      send_samples(N_CFG, 85, 90, 1'b0);
      drain_pipeline();
    end

    // heavy back pressure.
    send_samples(N_STALL, 60, 50, 1'b0);
    drain_pipeline();

    // full-scale samples with a scale near 15 must clip.
    write_cfg(2'd3, {16'd4, 16'hf000});
    pulse_srst();
    sat_before = sat_count;
    send_samples(N_SAT, 90, 80, 1'b1);
    drain_pipeline();
    assert (sat_count > sat_before) else
      stop_with_failure("the DUT sent no clipped outputs in the full-scale test");

    // four samples per frame reach the sync level quickly.
    write_cfg(2'd2, {8'h00, 24'd2});
    write_cfg(2'd3, {16'd2, 16'h1000});
    pulse_srst();
    send_samples(N_SYNC, 100, 100, 1'b0);
    drain_pipeline();
    assert (o_sync_ready === 1'b1 && g_frames == FRAME_MAX) else
      stop_with_failure("o_sync_ready did not rise after fifteen complete frames");
    pulse_srst();
    @(negedge clk);
    assert (o_sync_ready === 1'b0) else
      stop_with_failure("o_sync_ready stayed high after the restart");

    if (expected_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_with_failure("expected outputs were left over at the end of the run");
    end
  end

endmodule

`default_nettype wire

/* sin_table.hex */
// one column, sin(2*pi*k/128) in Q1.15 hex for k = 0 to 31, first quadrant of the turn.
0000
0648
0C8C
12C8
18F9
1F1A
2528
2B1F
30FC
36BA
3C56
41CE
471C
4C3F
5133
55F5
5A82
5ED7
62F1
66CF
6A6D
6DC9
70E2
73B5
7641
7884
7A7C
7C29
7D89
7E9C
7F61
7FD8

/* src.f */
+incdir+include
verilog/tag_rx_pkg.sv
verilog/chirp_cfg_if.sv
verilog/chirp_cfg_regs.sv
verilog/chirp_phase_gen.sv
verilog/dechirp_mixer.sv
verilog/scale_round_clip.sv
verilog/tag_rx.sv
bench/tag_rx_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tag_rx_tb
BUILD_DIR ?= build
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := src.f $(wildcard include/*.svh verilog/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f src.f -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	$(SIM) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)
